// ==== verilog/floppy_pkg.sv ====
package floppy_pkg;

    // ============================================================
    // Widths with a meaning
    // ============================================================
    typedef logic [7:0]  byte_t;
    typedef logic [12:0] buf_addr_t;    // Byte address in one track
    typedef logic [31:0] lba_t;         // Block address on the image
    typedef logic [6:0]  track_t;
    typedef logic [7:0]  sector_t;      // 1-based as seen by the host

    localparam int BLOCK_BYTES = 512;

    // ============================================================
    // Block device port
    // ============================================================
    typedef struct packed {
        lba_t       lba;
        logic [5:0] blk_cnt;            // Blocks minus one
        logic       rd;
        byte_t      buff_din;           // Read-back from the buffer
    } blk_req_t;

    typedef struct packed {
        logic       ack;
        buf_addr_t  buff_addr;
        byte_t      buff_dout;
        logic       buff_wr;
    } blk_rsp_t;

    // ============================================================
    // Host registers
    // ============================================================
    localparam logic [2:0] REG_CONTROL = 3'd0;
    localparam logic [2:0] REG_TRACK   = 3'd1;
    localparam logic [2:0] REG_SECTOR  = 3'd2;
    localparam logic [2:0] REG_STATUS  = 3'd3;
    localparam logic [2:0] REG_DATA    = 3'd4;

    localparam int CTRL_DRIVE_BIT  = 0;
    localparam int CTRL_SIDE_BIT   = 1;
    localparam int STAT_READY_BIT  = 0;
    localparam int STAT_MOUNT_BIT  = 1;
    localparam int STAT_RO_BIT     = 2;
    localparam int STAT_SECERR_BIT = 3;

endpackage

// ==== verilog/track_dpram.sv ====
`timescale 1ns/1ps

module track_dpram #(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 13
) (
    input  logic                  clk,

    input  logic [ADDR_WIDTH-1:0] address_a,
    input  logic [DATA_WIDTH-1:0] data_a,
    input  logic                  wren_a,
    output logic [DATA_WIDTH-1:0] q_a,

    input  logic [ADDR_WIDTH-1:0] address_b,
    output logic [DATA_WIDTH-1:0] q_b
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Port a, write side with write-through
    always_ff @(posedge clk) begin
        if (wren_a) begin
            mem[address_a] <= data_a;
            q_a            <= data_a;
        end else begin
            q_a <= mem[address_a];
        end
    end

    // Port b, read only
    always_ff @(posedge clk) begin
        q_b <= mem[address_b];
    end

endmodule

// ==== verilog/track_buffer.sv ====
`timescale 1ns/1ps

module track_buffer #(
    parameter int SECTORS_PER_TRACK = 9
) (
    input  logic                  clk,
    input  logic                  reset,

    input  floppy_pkg::track_t    track,
    input  logic                  drive_sel,
    input  logic                  side,

    input  floppy_pkg::buf_addr_t buffer_addr,
    output floppy_pkg::byte_t     buffer_q,
    output logic                  ready,

    input  logic                  disk_mounted,
    input  logic                  disk_sides,

    output floppy_pkg::blk_req_t  blk_req [2],
    input  floppy_pkg::blk_rsp_t  blk_rsp [2]
);

    import floppy_pkg::*;

    typedef enum logic [1:0] {
        idle,
        request,
        wait_ack,
        drain
    } load_state_t;

    localparam lba_t       SPT         = lba_t'(SECTORS_PER_TRACK);
    localparam logic [5:0] BLK_CNT     = 6'(SECTORS_PER_TRACK - 1);
    localparam int         TRACK_BYTES = SECTORS_PER_TRACK * BLOCK_BYTES;

    load_state_t state;
    track_t      track_q;
    logic        drive_q;
    logic        side_q;
    logic        load_pending;
    logic        rd_q;
    lba_t        lba_q;
    lba_t        track_lba;
    logic        changed;
    blk_rsp_t    rsp_sel;
    byte_t       read_back;
    logic        ram_wr;

    assign changed = {track_q, drive_q, side_q} != {track, drive_sel, side};
    assign ready   = disk_mounted && !changed && !load_pending && (state == idle);

    // Block address of the selected track and side
    assign track_lba = lba_t'(track) * (disk_sides ? (SPT + SPT) : SPT)
                     + (side ? SPT : lba_t'(0));

    // ============================================================
    // Load sequencing
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            load_pending <= 1'b1;
            rd_q         <= 1'b0;
            track_q      <= '0;
            drive_q      <= 1'b0;
            side_q       <= 1'b0;
        end else begin
            if (!disk_mounted) begin
                load_pending <= 1'b1;               // Reload on next mount
            end
            case (state)
                idle: begin
                    if (disk_mounted && (load_pending || changed)) begin
                        track_q      <= track;
                        drive_q      <= drive_sel;
                        side_q       <= side;
                        load_pending <= 1'b0;
                        state        <= request;
                    end
                end
                request: begin
                    rd_q  <= 1'b1;
                    state <= wait_ack;
                end
                wait_ack: begin
                    if (rsp_sel.ack) begin
                        rd_q  <= 1'b0;
                        state <= drain;
                    end
                end
                drain: begin
                    if (!rsp_sel.ack) begin
                        state <= idle;              // Device released ack
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle) begin
            lba_q <= track_lba;
        end
    end

    // ============================================================
    // Request and write routing
    // ============================================================
    always_comb begin
        for (int d = 0; d < 2; d++) begin
            blk_req[d] = '0;
            if (drive_q == 1'(d)) begin
                blk_req[d].lba      = lba_q;
                blk_req[d].blk_cnt  = BLK_CNT;
                blk_req[d].rd       = rd_q;
                blk_req[d].buff_din = read_back;
            end
        end
    end

    assign rsp_sel = blk_rsp[drive_q];
    assign ram_wr  = rsp_sel.buff_wr && (state != idle)
                  && (int'(rsp_sel.buff_addr) < TRACK_BYTES);

    track_dpram #(
        .DATA_WIDTH ($bits(byte_t)),
        .ADDR_WIDTH ($bits(buf_addr_t))
    ) u_ram (
        .clk       (clk),
        .address_a (rsp_sel.buff_addr),
        .data_a    (rsp_sel.buff_dout),
        .wren_a    (ram_wr),
        .q_a       (read_back),
        .address_b (buffer_addr),
        .q_b       (buffer_q)
    );

endmodule

// ==== verilog/sector_reader.sv ====
`timescale 1ns/1ps

module sector_reader #(
    parameter int SECTORS_PER_TRACK = 9
) (
    input  logic                  clk,
    input  logic                  reset,

    input  floppy_pkg::sector_t   sector,
    input  logic                  offset_clear,
    input  logic                  byte_taken,
    input  logic                  ready,

    output floppy_pkg::buf_addr_t buffer_addr,
    input  floppy_pkg::byte_t     buffer_q,

    output floppy_pkg::byte_t     data_byte,
    output logic                  data_valid,
    output logic                  sector_error
);

    import floppy_pkg::*;

    localparam int OFFSET_BITS = $clog2(BLOCK_BYTES);

    logic [OFFSET_BITS-1:0] offset;
    logic [OFFSET_BITS-1:0] offset_next;
    sector_t                sector_index;
    logic                   settled;

    always_comb begin
        if (offset_clear) begin
            offset_next = '0;
        end else if (byte_taken) begin
            offset_next = offset + 1'b1;        // Wraps after 511
        end else begin
            offset_next = offset;
        end
    end

    assign sector_index = sector - sector_t'(1);
    assign sector_error = (sector == '0) || (sector > sector_t'(SECTORS_PER_TRACK));

    // ============================================================
    // Prefetch pipeline
    // ============================================================
    // Address is built from the next offset so the RAM output
    // carries the new byte two cycles after the event
    always_ff @(posedge clk) begin
        if (reset) begin
            offset      <= '0;
            buffer_addr <= '0;
            settled     <= 1'b0;
        end else begin
            offset      <= offset_next;
            buffer_addr <= buf_addr_t'(sector_index) * buf_addr_t'(BLOCK_BYTES)
                         + buf_addr_t'(offset_next);
            settled     <= !(offset_clear || byte_taken);
        end
    end

    assign data_byte  = buffer_q;
    assign data_valid = ready && !sector_error && settled;

endmodule

// ==== verilog/fdc_regs.sv ====
`timescale 1ns/1ps

module fdc_regs (
    input  logic                clk,
    input  logic                reset,

    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [2:0]          wb_adr,
    input  floppy_pkg::byte_t   wb_dat_w,
    output floppy_pkg::byte_t   wb_dat_r,
    output logic                wb_ack,

    input  logic                ready,
    input  logic                disk_mounted,
    input  logic                disk_readonly,
    input  floppy_pkg::byte_t   data_byte,
    input  logic                data_valid,
    input  logic                sector_error,

    output logic                drive_sel,
    output logic                side,
    output floppy_pkg::track_t  track,
    output floppy_pkg::sector_t sector,
    output logic                offset_clear,
    output logic                byte_taken
);

    import floppy_pkg::*;

    logic  access_done;
    logic  start;
    byte_t status;
    byte_t read_mux;

    // One ack per strobe
    assign start = wb_cyc && wb_stb && !access_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack      <= 1'b0;
            access_done <= 1'b0;
        end else begin
            wb_ack      <= start;
            access_done <= wb_cyc && wb_stb;
        end
    end

    // ============================================================
    // Read path
    // ============================================================
    always_comb begin
        status                  = '0;
        status[STAT_READY_BIT]  = ready;
        status[STAT_MOUNT_BIT]  = disk_mounted;
        status[STAT_RO_BIT]     = disk_readonly;
        status[STAT_SECERR_BIT] = sector_error;
    end

    always_comb begin
        read_mux = '0;
        case (wb_adr)
            REG_CONTROL: begin
                read_mux[CTRL_DRIVE_BIT] = drive_sel;
                read_mux[CTRL_SIDE_BIT]  = side;
            end
            REG_TRACK:  read_mux = byte_t'(track);
            REG_SECTOR: read_mux = sector;
            REG_STATUS: read_mux = status;
            REG_DATA:   read_mux = data_valid ? data_byte : '0;  // Zero while not ready
            default:    read_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start && !wb_we) begin
            wb_dat_r <= read_mux;
        end
    end

    // ============================================================
    // Write path and strobes
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            drive_sel    <= 1'b0;
            side         <= 1'b0;
            track        <= '0;
            sector       <= sector_t'(1);
            offset_clear <= 1'b0;
            byte_taken   <= 1'b0;
        end else begin
            offset_clear <= 1'b0;
            byte_taken   <= 1'b0;
            if (start && wb_we) begin
                case (wb_adr)
                    REG_CONTROL: begin
                        drive_sel <= wb_dat_w[CTRL_DRIVE_BIT];
                        side      <= wb_dat_w[CTRL_SIDE_BIT];
                    end
                    REG_TRACK: track <= track_t'(wb_dat_w);
                    REG_SECTOR: begin
                        sector       <= wb_dat_w;
                        offset_clear <= 1'b1;      // Restart at byte 0
                    end
                    default: ;
                endcase
            end
            if (start && !wb_we && (wb_adr == REG_DATA) && data_valid) begin
                byte_taken <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/floppy_top.sv ====
`timescale 1ns/1ps

module floppy_top #(
    parameter int SECTORS_PER_TRACK = 9
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [2:0]           wb_adr,
    input  floppy_pkg::byte_t    wb_dat_w,
    output floppy_pkg::byte_t    wb_dat_r,
    output logic                 wb_ack,

    input  logic                 disk_mounted,
    input  logic                 disk_readonly,
    input  logic                 disk_sides,

    output floppy_pkg::blk_req_t blk_req [2],
    input  floppy_pkg::blk_rsp_t blk_rsp [2]
);

    import floppy_pkg::*;

    logic      drive_sel;
    logic      side;
    track_t    track;
    sector_t   sector;
    logic      offset_clear;
    logic      byte_taken;
    byte_t     data_byte;
    logic      data_valid;
    logic      sector_error;
    logic      ready;
    buf_addr_t buffer_addr;
    byte_t     buffer_q;

    fdc_regs u_regs (
        .clk           (clk),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .ready         (ready),
        .disk_mounted  (disk_mounted),
        .disk_readonly (disk_readonly),
        .data_byte     (data_byte),
        .data_valid    (data_valid),
        .sector_error  (sector_error),
        .drive_sel     (drive_sel),
        .side          (side),
        .track         (track),
        .sector        (sector),
        .offset_clear  (offset_clear),
        .byte_taken    (byte_taken)
    );

    sector_reader #(
        .SECTORS_PER_TRACK (SECTORS_PER_TRACK)
    ) u_reader (
        .clk          (clk),
        .reset        (reset),
        .sector       (sector),
        .offset_clear (offset_clear),
        .byte_taken   (byte_taken),
        .ready        (ready),
        .buffer_addr  (buffer_addr),
        .buffer_q     (buffer_q),
        .data_byte    (data_byte),
        .data_valid   (data_valid),
        .sector_error (sector_error)
    );

    track_buffer #(
        .SECTORS_PER_TRACK (SECTORS_PER_TRACK)
    ) u_track (
        .clk          (clk),
        .reset        (reset),
        .track        (track),
        .drive_sel    (drive_sel),
        .side         (side),
        .buffer_addr  (buffer_addr),
        .buffer_q     (buffer_q),
        .ready        (ready),
        .disk_mounted (disk_mounted),
        .disk_sides   (disk_sides),
        .blk_req      (blk_req),
        .blk_rsp      (blk_rsp)
    );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== verif/block_device_model.sv ====
`timescale 1ns/1ps

module block_device_model #(
    parameter int MAX_DELAY = 64
) (
    input  logic                 clk,
    input  logic                 reset,
    input  floppy_pkg::blk_req_t blk_req [2],
    output floppy_pkg::blk_rsp_t blk_rsp [2]
);

    import floppy_pkg::*;

    // Image content, a function of block address, offset and drive
    function automatic byte_t block_byte(input lba_t lba, input int offset, input logic drive);
        logic [8:0] o;
        byte_t      value;
        o     = 9'(offset);
        value = (lba[7:0] + o[7:0]) ^ {o[8], 7'b0};
        return drive ? (value ^ 8'h5A) : value;
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // ============================================================
    // One responder per drive
    // ============================================================
    for (genvar d = 0; d < 2; d++) begin : g_drive
        blk_rsp_t rsp;

        assign blk_rsp[d] = rsp;

        initial begin : serve
            lba_t        lba;
            logic [5:0]  cnt;
            logic [31:0] seed;
            int          delay;
            int          total;
            seed = 32'h3d80;
            rsp <= '0;
            forever begin
                @(negedge clk);
                if (!reset && blk_req[d].rd) begin
                    lba   = blk_req[d].lba;
                    cnt   = blk_req[d].blk_cnt;
                    seed  = lcg_step(seed);
                    delay = int'((seed >> 16) % MAX_DELAY);
                    total = (int'(cnt) + 1) * BLOCK_BYTES;
                    repeat (delay) @(posedge clk);     // Seek time
                    for (int i = 0; i < total; i++) begin
                        @(posedge clk);
                        rsp.buff_wr   <= 1'b1;
                        rsp.buff_addr <= buf_addr_t'(i);
                        rsp.buff_dout <= block_byte(lba + lba_t'(i / BLOCK_BYTES),
                                                    i % BLOCK_BYTES, 1'(d));
                    end
                    @(posedge clk);
                    rsp.buff_wr <= 1'b0;
                    rsp.ack     <= 1'b1;
                    do begin
                        @(negedge clk);
                    end while (blk_req[d].rd);         // Hold ack until rd drops
                    @(posedge clk);
                    rsp <= '0;
                end
            end
        end
    end

endmodule

// ==== verif/floppy_tb.sv ====
`timescale 1ns/1ps

module floppy_tb;

    import floppy_pkg::*;

    localparam int SPT             = 9;
    localparam int MAX_DELAY       = 64;
    localparam int LOAD_CYCLES     = MAX_DELAY + SPT * BLOCK_BYTES + 16;
    localparam int NUM_LOADS       = 8;
    localparam int HOST_CYCLES     = 4000;
    localparam int WATCHDOG_CYCLES = NUM_LOADS * LOAD_CYCLES + HOST_CYCLES;
    localparam int READY_POLLS     = LOAD_CYCLES;      // Covers a load queued behind another
    localparam int ACK_LIMIT       = 16;

    logic     clk;
    logic     reset;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    logic [2:0] wb_adr;
    byte_t    wb_dat_w;
    byte_t    wb_dat_r;
    logic     wb_ack;
    logic     disk_mounted;
    logic     disk_readonly;
    logic     disk_sides;
    blk_req_t blk_req [2];
    blk_rsp_t blk_rsp [2];

    int          errors;
    int          monitor_errors;
    int          checks;
    int unsigned req_count [2];
    logic [1:0]  rd_prev;
    logic [1:0]  wr_prev;
    byte_t       dout_prev [2];
    logic [31:0] rand_state;

    // Host view of the selection
    int   cur_track;
    logic cur_side;
    logic cur_drive;
    int   cur_sector;
    logic sides;
    int   exp_offset;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    floppy_top #(
        .SECTORS_PER_TRACK (SPT)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .disk_mounted  (disk_mounted),
        .disk_readonly (disk_readonly),
        .disk_sides    (disk_sides),
        .blk_req       (blk_req),
        .blk_rsp       (blk_rsp)
    );

    block_device_model #(
        .MAX_DELAY (MAX_DELAY)
    ) u_model (
        .clk     (clk),
        .reset   (reset),
        .blk_req (blk_req),
        .blk_rsp (blk_rsp)
    );

    // ============================================================
    // Reference model
    // ============================================================
    function automatic lba_t track_lba(input int trk, input logic sd, input logic two_sided);
        return lba_t'(trk) * lba_t'(two_sided ? 2 * SPT : SPT) + lba_t'(sd ? SPT : 0);
    endfunction

    function automatic byte_t expected_byte(input lba_t lba, input int offset, input logic drv);
        logic [8:0] o;
        byte_t      b;
        o = 9'(offset);
        b = lba[7:0] + o[7:0];
        b = b ^ {o[8], 7'b0};               // Second half of the block
        if (drv) begin
            b = b ^ 8'h5A;
        end
        return b;
    endfunction

    function automatic int unsigned random_below(input int unsigned n);
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return (rand_state >> 16) % n;
    endfunction

    // ============================================================
    // Host bus tasks
    // ============================================================
    task automatic bus_cycle(input logic we, input logic [2:0] adr, input byte_t wdata,
                             output byte_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        rdata = wb_dat_r;
        if (!wb_ack) begin
            $display("No wb_ack within %0d cycles at %0t", ACK_LIMIT, $time);
            errors++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] adr, input byte_t data);
        byte_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input logic [2:0] adr, output byte_t data);
        bus_cycle(1'b0, adr, 8'h00, data);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ready();
        byte_t status;
        int    polls;
        status = '0;
        polls  = 0;
        while (!status[STAT_READY_BIT] && polls < READY_POLLS) begin
            read_reg(REG_STATUS, status);
            polls++;
        end
        if (!status[STAT_READY_BIT]) begin
            $display("Track load not finished after %0d status polls at %0t", polls, $time);
            errors++;
        end
    endtask

    task automatic select_sector(input int s);
        write_reg(REG_SECTOR, byte_t'(s));
        cur_sector = s;
        exp_offset = 0;
    endtask

    task automatic select_track(input int trk, input logic sd, input logic drv);
        write_reg(REG_CONTROL, byte_t'({sd, drv}));
        write_reg(REG_TRACK, byte_t'(trk));
        cur_track = trk;
        cur_side  = sd;
        cur_drive = drv;
    endtask

    task automatic read_and_check(input int count);
        byte_t got;
        lba_t  lba;
        lba = track_lba(cur_track, cur_side, sides) + lba_t'(cur_sector - 1);
        for (int i = 0; i < count; i++) begin
            read_reg(REG_DATA, got);
            check_value("wb_dat_r (data)", 32'(got),
                        32'(expected_byte(lba, exp_offset, cur_drive)));
            exp_offset = (exp_offset + 1) % BLOCK_BYTES;
        end
    endtask

    task automatic expect_reg(input logic [2:0] adr, input byte_t exp, input string name);
        byte_t got;
        read_reg(adr, got);
        check_value(name, 32'(got), 32'(exp));
    endtask

    // ============================================================
    // Block request monitor
    // ============================================================
    always @(negedge clk) begin
        if (!reset) begin
            assert (!(blk_req[0].rd && blk_req[1].rd)) else begin
                $display("Both drives had rd high at the same time at %0t", $time);
                monitor_errors++;
            end
            for (int d = 0; d < 2; d++) begin
                if (blk_req[d].rd && !rd_prev[d]) begin
                    req_count[d]++;
                    assert (blk_req[d].blk_cnt == 6'(SPT - 1)) else begin
                        $display("ERR %0t blk_req[%0d].blk_cnt got %0h expected %0h",
                                 $time, d, blk_req[d].blk_cnt, SPT - 1);
                        monitor_errors++;
                    end
                end
                if (wr_prev[d]) begin                   // Port a writes through
                    assert (blk_req[d].buff_din == dout_prev[d]) else begin
                        $display("ERR %0t blk_req[%0d].buff_din got %0h expected %0h",
                                 $time, d, blk_req[d].buff_din, dout_prev[d]);
                        monitor_errors++;
                    end
                end
                rd_prev[d]   = blk_req[d].rd;
                wr_prev[d]   = blk_rsp[d].buff_wr;
                dout_prev[d] = blk_rsp[d].buff_dout;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + monitor_errors + 1);
        $display("Done: errors found");
        $finish;
    end

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin : stimulus
        int          trk;
        int unsigned prev_req [2];
        errors         = 0;
        monitor_errors = 0;
        checks         = 0;
        req_count[0]   = 0;
        req_count[1]   = 0;
        rd_prev        = '0;
        wr_prev        = '0;
        rand_state     = 32'h3d80;
        cur_track      = 0;
        cur_side       = 1'b0;
        cur_drive      = 1'b0;
        cur_sector     = 1;
        sides          = 1'b1;
        exp_offset     = 0;
        wb_cyc        <= 1'b0;
        wb_stb        <= 1'b0;
        wb_we         <= 1'b0;
        wb_adr        <= '0;
        wb_dat_w      <= '0;
        disk_mounted  <= 1'b0;
        disk_readonly <= 1'b1;
        disk_sides    <= 1'b1;

        @(negedge clk);
        while (reset) @(negedge clk);

        // Reset state, then first mount
        check_value("wb_ack", 32'(wb_ack), 32'd0);
        check_value("blk_req[0].rd", 32'(blk_req[0].rd), 32'd0);
        check_value("blk_req[1].rd", 32'(blk_req[1].rd), 32'd0);
        expect_reg(REG_STATUS, 8'h04, "status (unmounted)");   // Read-only only
        @(posedge clk);
        disk_mounted <= 1'b1;
        wait_ready();
        expect_reg(REG_STATUS, 8'h07, "status (mounted)");
        check_value("drive 0 requests", req_count[0], 32'd1);
        check_value("drive 1 requests", req_count[1], 32'd0);
        read_and_check(16);

        // Full sector with wrap to offset 0
        select_sector(1 + int'(random_below(SPT)));
        read_and_check(BLOCK_BYTES + 4);

        // Side 1 on a double-sided image
        trk = int'(random_below(80));
        select_track(trk, 1'b1, 1'b0);
        wait_ready();
        select_sector(1 + int'(random_below(SPT)));
        read_and_check(8);

        // Single-sided image, set while unmounted
        @(posedge clk);
        disk_mounted <= 1'b0;
        disk_sides   <= 1'b0;
        sides = 1'b0;
        trk = int'(random_below(80));
        select_track(trk, 1'b0, 1'b0);
        expect_reg(REG_STATUS, 8'h04, "status (unmounted)");
        @(posedge clk);
        disk_mounted <= 1'b1;
        wait_ready();
        select_sector(1 + int'(random_below(SPT)));
        read_and_check(8);

        // Drive 1
        prev_req[0] = req_count[0];
        prev_req[1] = req_count[1];
        select_track(cur_track, 1'b0, 1'b1);
        wait_ready();
        check_value("drive 0 requests", req_count[0], prev_req[0]);
        check_value("drive 1 requests", req_count[1], prev_req[1] + 1);
        @(posedge clk);
        disk_readonly <= 1'b0;
        expect_reg(REG_STATUS, 8'h03, "status (writable)");
        select_sector(1 + int'(random_below(SPT)));
        read_and_check(8);

        // Reads while a new track loads
        trk = (cur_track + 1 + int'(random_below(40))) % 80;
        write_reg(REG_TRACK, byte_t'(trk));
        cur_track = trk;
        expect_reg(REG_STATUS, 8'h02, "status (loading)");
        for (int i = 0; i < 3; i++) begin
            expect_reg(REG_DATA, 8'h00, "wb_dat_r (data while loading)");
        end
        wait_ready();
        read_and_check(8);                  // Offset kept across the load

        // Sector out of range
        select_sector(0);
        expect_reg(REG_STATUS, 8'h0B, "status (sector 0)");
        expect_reg(REG_DATA, 8'h00, "wb_dat_r (sector 0)");
        select_sector(SPT + 1);
        expect_reg(REG_STATUS, 8'h0B, "status (sector too high)");
        expect_reg(REG_DATA, 8'h00, "wb_dat_r (sector too high)");
        select_sector(SPT);
        read_and_check(4);

        errors = errors + monitor_errors;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/floppy_pkg.sv
verilog/track_dpram.sv
verilog/track_buffer.sv
verilog/sector_reader.sv
verilog/fdc_regs.sv
verilog/floppy_top.sv
verif/tb_clock.sv
verif/block_device_model.sv
verif/floppy_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module floppy_tb -o floppy_sim

out=$(./obj_dir/floppy_sim)
echo "$out"

echo "$out" | grep -qx "Done: no errors"
echo "Simulation passed"
